// ==== gfx_mem_cfg.svh ====
// global sizes for the pixel memory port
// address, line and bit offset widths
// command queue depth and writer credit count
`ifndef GFX_MEM_CFG_SVH
`define GFX_MEM_CFG_SVH

// byte address width
`define GFX_ADDR_W 32
// one memory line, moved as a single bus word
`define GFX_LINE_W 128
// mb / me offsets inside a line
`define GFX_BITOFS_W 7
// queue entries, also source credits after reset
`define GFX_CMD_DEPTH 4
// writer works on one command at a time
`define GFX_WR_CREDITS 1

`endif

// ==== gfx_bus_pkg.sv ====
// bus side types of the memory port
// line data word, byte selects, line number
// plus derived line geometry

`include "gfx_mem_cfg.svh"

package gfx_bus_pkg;

  // bytes per line and low address bits inside a line
  localparam int LINE_BYTES = `GFX_LINE_W / 8;
  localparam int LINE_OFS_W = $clog2(LINE_BYTES);

  // one full memory line
  typedef logic [`GFX_LINE_W-1:0] line_t;

  // one select per byte lane
  typedef logic [LINE_BYTES-1:0] sel_t;

  // line number, byte address without the in-line offset
  typedef logic [`GFX_ADDR_W-1:LINE_OFS_W] line_adr_t;

endpackage

// ==== gfx_pixel_pkg.sv ====
// pixel command types
// command kind, render data word with colour and depth views,
// full queued command

`include "gfx_mem_cfg.svh"

package gfx_pixel_pkg;

  typedef enum logic {
    PIX_COLOR = 1'b0, // rmw merge into the line buffer
    PIX_DEPTH = 1'b1  // direct 16 bit store
  } pix_kind_e;

  // depth view, z sits in the low half
  typedef struct packed {
    logic [15:0] unused;
    logic [15:0] z;
  } pix_depth_t;

  // same render word, read per command kind
  typedef union packed {
    logic [31:0] color; // raw bits, shifted by mb
    pix_depth_t  depth;
  } pix_data_u;

  typedef struct packed {
    pix_kind_e                kind;
    logic [`GFX_ADDR_W-1:0]   adr;  // byte address
    pix_data_u                data;
    logic [`GFX_BITOFS_W-1:0] mb;   // first bit of field
    logic [`GFX_BITOFS_W-1:0] me;   // last bit, may wrap below mb
  } pix_cmd_t;

endpackage

// ==== gfx_pix_if.sv ====
// pixel command link between command queue and writer
// valid + command forward, credit pulse back
// source side is the queue, sink side the writer
`timescale 1ns/1ps

`include "gfx_mem_cfg.svh"

interface gfx_pix_if
  import gfx_pixel_pkg::*;
();

  logic     valid;  // one command per cycle high
  pix_cmd_t cmd;
  logic     credit; // one pulse per finished command

  modport source (
    output valid,
    output cmd,
    input  credit
  );

  modport sink (
    input  valid,
    input  cmd,
    output credit
  );

endinterface

// ==== gfx_wb_if.sv ====
// one wishbone style classic master connection
// 128 bit data, byte selects, ack and err completion
// master and slave views
`timescale 1ns/1ps

`include "gfx_mem_cfg.svh"

interface gfx_wb_if
  import gfx_bus_pkg::*;
();

  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [`GFX_ADDR_W-1:0] adr;   // byte address, line aligned
  sel_t                   sel;
  line_t                  dat_w; // master to slave
  line_t                  dat_r; // slave to master
  logic                   ack;
  logic                   err;   // also ends the cycle

  modport master (
    output cyc, stb, we, adr, sel, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, sel, dat_w,
    output dat_r, ack, err
  );

endinterface

// ==== gfx_cmd_queue.sv ====
// command queue in front of the pixel writer
// circular buffer fed by a credit based source
// forwards the head entry while the writer grants a credit
// returns one source credit per popped entry
`timescale 1ns/1ps

`include "gfx_mem_cfg.svh"

module gfx_cmd_queue
  import gfx_pixel_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      cmd_valid_i,
  input  pix_cmd_t  cmd_i,
  output logic      cmd_credit_o,
  gfx_pix_if.source pix_o
);

  localparam int PTR_W = $clog2(`GFX_CMD_DEPTH);
  localparam int CNT_W = $clog2(`GFX_CMD_DEPTH + 1);
  localparam int CRD_W = $clog2(`GFX_WR_CREDITS + 1);

  pix_cmd_t         mem_q [`GFX_CMD_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CRD_W-1:0] wr_crd_q; // credits held from the writer
  logic             pop;

  // head leaves whenever the writer can take it
  assign pop = (count_q != '0) && (wr_crd_q != '0);

  assign pix_o.valid = pop;
  assign pix_o.cmd   = mem_q[rd_ptr_q];

  // storage, source never writes without a credit so no full check
  always_ff @(posedge clk_i)
    if (cmd_valid_i)
      mem_q[wr_ptr_q] <= cmd_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      wr_crd_q     <= CRD_W'(`GFX_WR_CREDITS);
      cmd_credit_o <= 1'b0;
    end
    else
    begin
      if (cmd_valid_i)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`GFX_CMD_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`GFX_CMD_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({cmd_valid_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
      case ({pix_o.credit, pop})
        2'b10:   wr_crd_q <= wr_crd_q + 1'b1;
        2'b01:   wr_crd_q <= wr_crd_q - 1'b1;
        default: wr_crd_q <= wr_crd_q;
      endcase
      cmd_credit_o <= pop; // slot freed, give it back to the source
    end
  end

endmodule

// ==== gfx_wbm_write.sv ====
// write combining pixel writer
// one line buffer with address and dirty flag
// colour commands merge a bit field by read-modify-write
// depth commands store 16 bits straight to memory
// snoop port lets the line reader see the buffer
`timescale 1ns/1ps

`include "gfx_mem_cfg.svh"

module gfx_wbm_write
  import gfx_bus_pkg::*;
  import gfx_pixel_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  gfx_pix_if.sink   pix_i,
  gfx_wb_if.master  wb_o,
  input  line_adr_t snoop_adr_i,
  output logic      snoop_hit_o,
  output line_t     snoop_line_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WBACK,    // dirty line going out
    ST_RD_START, // bus idle cycle between write back and fetch
    ST_RD_WAIT,  // fetching the new line
    ST_MERGE,
    ST_DEPTH     // z store in flight
  } state_e;

  state_e                 state_q;
  pix_cmd_t               cmd_q;
  line_t                  buf_q;
  line_adr_t              buf_adr_q; // all ones = nothing buffered
  logic                   dirty_q;
  logic                   credit_q;
  logic                   cyc_q;
  logic                   we_q;
  logic [`GFX_ADDR_W-1:0] adr_q;
  sel_t                   sel_q;
  line_t                  dat_q;

  line_adr_t new_line; // line of the incoming command
  line_adr_t cmd_line; // line of the held command
  line_t     mask;
  line_t     shifted;
  line_t     merged;
  logic      done;

  assign new_line = pix_i.cmd.adr[`GFX_ADDR_W-1:LINE_OFS_W];
  assign cmd_line = cmd_q.adr[`GFX_ADDR_W-1:LINE_OFS_W];
  assign done     = wb_o.ack || wb_o.err; // err also ends the cycle

  // field mask, wraps around the line top when me < mb
  always_comb
  begin
    for (int n = 0; n < `GFX_LINE_W; n++)
      mask[n] = (n >= cmd_q.mb) ^ (n <= cmd_q.me) ^ (cmd_q.me >= cmd_q.mb);
  end

  always_comb
  begin
    shifted = line_t'(cmd_q.data.color) << cmd_q.mb;
    merged  = (shifted & mask) | (buf_q & ~mask);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q   <= ST_IDLE;
      cyc_q     <= 1'b0;
      we_q      <= 1'b0;
      dirty_q   <= 1'b0;
      credit_q  <= 1'b0;
      buf_adr_q <= '1;
    end
    else
    begin
      credit_q <= 1'b0; // pulse only
      case (state_q)
        ST_IDLE:
          if (pix_i.valid)
          begin
            cmd_q <= pix_i.cmd;
            if (pix_i.cmd.kind == PIX_DEPTH)
            begin
              cyc_q   <= 1'b1;
              we_q    <= 1'b1;
              adr_q   <= {new_line, {LINE_OFS_W{1'b0}}};
              sel_q   <= sel_t'(2'b11) << pix_i.cmd.mb[`GFX_BITOFS_W-1:3];
              dat_q   <= {(`GFX_LINE_W / 16){pix_i.cmd.data.depth.z}}; // z on every lane
              state_q <= ST_DEPTH;
            end
            else if (new_line == buf_adr_q)
              state_q <= ST_MERGE; // same line, no bus
            else if (dirty_q)
            begin
              cyc_q   <= 1'b1;
              we_q    <= 1'b1;
              adr_q   <= {buf_adr_q, {LINE_OFS_W{1'b0}}};
              sel_q   <= '1;
              dat_q   <= buf_q;
              state_q <= ST_WBACK;
            end
            else
            begin
              cyc_q   <= 1'b1; // clean miss, fetch at once
              we_q    <= 1'b0;
              adr_q   <= {new_line, {LINE_OFS_W{1'b0}}};
              sel_q   <= '1;
              state_q <= ST_RD_WAIT;
            end
          end
        ST_WBACK:
          if (done)
          begin
            cyc_q   <= 1'b0;
            we_q    <= 1'b0;
            dirty_q <= 1'b0;
            state_q <= ST_RD_START;
          end
        ST_RD_START:
        begin
          cyc_q   <= 1'b1;
          adr_q   <= {cmd_line, {LINE_OFS_W{1'b0}}};
          sel_q   <= '1;
          state_q <= ST_RD_WAIT;
        end
        ST_RD_WAIT:
          if (done)
          begin
            cyc_q     <= 1'b0;
            buf_q     <= wb_o.dat_r;
            buf_adr_q <= cmd_line;
            state_q   <= ST_MERGE;
          end
        ST_MERGE:
        begin
          buf_q    <= merged;
          dirty_q  <= 1'b1;
          credit_q <= 1'b1;
          state_q  <= ST_IDLE;
        end
        ST_DEPTH:
          if (done)
          begin
            cyc_q    <= 1'b0;
            we_q     <= 1'b0;
            credit_q <= 1'b1;
            // keep buffered copy in step with memory, dirty unchanged
            if (cmd_line == buf_adr_q)
              for (int b = 0; b < LINE_BYTES; b++)
                if (sel_q[b])
                  buf_q[b*8 +: 8] <= dat_q[b*8 +: 8];
            state_q <= ST_IDLE;
          end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign pix_i.credit = credit_q;

  assign wb_o.cyc   = cyc_q;
  assign wb_o.stb   = cyc_q; // classic cycles only
  assign wb_o.we    = we_q;
  assign wb_o.adr   = adr_q;
  assign wb_o.sel   = sel_q;
  assign wb_o.dat_w = dat_q;

  // snoop, hit now, line one cycle later
  assign snoop_hit_o = (snoop_adr_i == buf_adr_q);

  always_ff @(posedge clk_i)
    if (snoop_hit_o)
      snoop_line_o <= buf_q;

endmodule

// ==== gfx_wbm_read.sv ====
// line reader
// one request at a time, writer buffer snooped first
// full select bus read on a snoop miss
`timescale 1ns/1ps

`include "gfx_mem_cfg.svh"

module gfx_wbm_read
  import gfx_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      rd_req_i,
  input  line_adr_t rd_adr_i,
  output logic      rd_ready_o,
  output logic      rd_valid_o,
  output line_t     rd_data_o,
  output line_adr_t snoop_adr_o,
  input  logic      snoop_hit_i,
  input  line_t     snoop_line_i,
  gfx_wb_if.master  wb_o
);

  typedef enum logic [1:0] {RD_IDLE, RD_LOOKUP, RD_BUS} state_e;

  state_e    state_q;
  line_adr_t adr_q;
  line_t     line_q;      // line from memory
  logic      use_snoop_q; // answer comes from the writer buffer
  logic      cyc_q;
  logic      valid_q;

  assign rd_ready_o  = (state_q == RD_IDLE);
  assign snoop_adr_o = adr_q;
  assign rd_valid_o  = valid_q;
  assign rd_data_o   = use_snoop_q ? snoop_line_i : line_q; // snoop line lands with valid

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q     <= RD_IDLE;
      cyc_q       <= 1'b0;
      valid_q     <= 1'b0;
      use_snoop_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      case (state_q)
        RD_IDLE:
          if (rd_req_i)
          begin
            adr_q   <= rd_adr_i;
            state_q <= RD_LOOKUP;
          end
        RD_LOOKUP:
          if (snoop_hit_i)
          begin
            use_snoop_q <= 1'b1;
            valid_q     <= 1'b1;
            state_q     <= RD_IDLE;
          end
          else
          begin
            cyc_q   <= 1'b1; // miss, go to memory
            state_q <= RD_BUS;
          end
        RD_BUS:
          if (wb_o.ack || wb_o.err)
          begin
            cyc_q       <= 1'b0;
            line_q      <= wb_o.dat_r;
            use_snoop_q <= 1'b0;
            valid_q     <= 1'b1;
            state_q     <= RD_IDLE;
          end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  assign wb_o.cyc   = cyc_q;
  assign wb_o.stb   = cyc_q;
  assign wb_o.we    = 1'b0;  // read only master
  assign wb_o.adr   = {adr_q, {LINE_OFS_W{1'b0}}};
  assign wb_o.sel   = '1;
  assign wb_o.dat_w = '0;

endmodule

// ==== gfx_wb_arbiter.sv ====
// two master bus arbiter, writer before reader
// owner kept until it drops cyc
// sticky error flag for the host interrupt
`timescale 1ns/1ps

module gfx_wb_arbiter (
  input  logic     clk_i,
  input  logic     rst_i,
  gfx_wb_if.slave  wr_i,
  gfx_wb_if.slave  rd_i,
  gfx_wb_if.master mem_o,
  output logic     err_o
);

  typedef enum logic [1:0] {OWN_NONE, OWN_WR, OWN_RD} owner_e;

  owner_e owner_q;
  owner_e owner_d;
  logic   own_wr;
  logic   own_rd;

  assign own_wr = (owner_q == OWN_WR);
  assign own_rd = (owner_q == OWN_RD);

  // regrant only once the current owner has let go
  always_comb
  begin
    owner_d = owner_q;
    if (!(own_wr && wr_i.cyc) && !(own_rd && rd_i.cyc))
      owner_d = wr_i.cyc ? OWN_WR : (rd_i.cyc ? OWN_RD : OWN_NONE);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      owner_q <= OWN_NONE;
      err_o   <= 1'b0;
    end
    else
    begin
      owner_q <= owner_d;
      if (mem_o.err)
        err_o <= 1'b1; // held until reset
    end
  end

  // fields from the owner, bus quiet without one
  assign mem_o.cyc   = (own_wr && wr_i.cyc) || (own_rd && rd_i.cyc);
  assign mem_o.stb   = (own_wr && wr_i.stb) || (own_rd && rd_i.stb);
  assign mem_o.we    = own_rd ? rd_i.we    : wr_i.we;
  assign mem_o.adr   = own_rd ? rd_i.adr   : wr_i.adr;
  assign mem_o.sel   = own_rd ? rd_i.sel   : wr_i.sel;
  assign mem_o.dat_w = own_rd ? rd_i.dat_w : wr_i.dat_w;

  // read data shared, completions to the owner only
  assign wr_i.dat_r = mem_o.dat_r;
  assign rd_i.dat_r = mem_o.dat_r;
  assign wr_i.ack   = own_wr && mem_o.ack;
  assign rd_i.ack   = own_rd && mem_o.ack;
  assign wr_i.err   = own_wr && mem_o.err;
  assign rd_i.err   = own_rd && mem_o.err;

endmodule

// ==== gfx_mem_port.sv ====
// pixel memory port top level
// command queue, pixel writer, line reader, bus arbiter
// command, read and memory bus on plain ports
`timescale 1ns/1ps

`include "gfx_mem_cfg.svh"

module gfx_mem_port
  import gfx_bus_pkg::*;
  import gfx_pixel_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  // renderer commands, credit flow control
  input  logic                     cmd_valid_i,
  input  pix_kind_e                cmd_kind_i,
  input  logic [`GFX_ADDR_W-1:0]   cmd_adr_i,
  input  logic [31:0]              cmd_dat_i,
  input  logic [`GFX_BITOFS_W-1:0] cmd_mb_i,
  input  logic [`GFX_BITOFS_W-1:0] cmd_me_i,
  output logic                     cmd_credit_o,
  // line reads
  input  logic                     rd_req_i,
  input  line_adr_t                rd_adr_i,
  output logic                     rd_ready_o,
  output logic                     rd_valid_o,
  output line_t                    rd_data_o,
  // memory bus
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [`GFX_ADDR_W-1:0]   wb_adr_o,
  output sel_t                     wb_sel_o,
  output line_t                    wb_dat_o,
  input  line_t                    wb_dat_i,
  input  logic                     wb_ack_i,
  input  logic                     wb_err_i,
  output logic                     irq_o
);

  pix_cmd_t  cmd_in;
  line_adr_t snoop_adr;
  logic      snoop_hit;
  line_t     snoop_line;

  gfx_pix_if pix_link ();
  gfx_wb_if  wr_bus ();
  gfx_wb_if  rd_bus ();
  gfx_wb_if  mem_bus ();

  assign cmd_in.kind       = cmd_kind_i;
  assign cmd_in.adr        = cmd_adr_i;
  assign cmd_in.data.color = cmd_dat_i; // raw word, writer picks the view
  assign cmd_in.mb         = cmd_mb_i;
  assign cmd_in.me         = cmd_me_i;

  gfx_cmd_queue i_cmd_queue (
    .clk_i, .rst_i, .cmd_valid_i, .cmd_i(cmd_in), .cmd_credit_o, .pix_o(pix_link)
  );

  gfx_wbm_write i_wbm_write (
    .clk_i, .rst_i, .pix_i(pix_link), .wb_o(wr_bus),
    .snoop_adr_i(snoop_adr), .snoop_hit_o(snoop_hit), .snoop_line_o(snoop_line)
  );

  gfx_wbm_read i_wbm_read (
    .clk_i, .rst_i, .rd_req_i, .rd_adr_i, .rd_ready_o, .rd_valid_o, .rd_data_o,
    .snoop_adr_o(snoop_adr), .snoop_hit_i(snoop_hit), .snoop_line_i(snoop_line),
    .wb_o(rd_bus)
  );

  gfx_wb_arbiter i_wb_arbiter (
    .clk_i, .rst_i, .wr_i(wr_bus), .rd_i(rd_bus), .mem_o(mem_bus), .err_o(irq_o)
  );

  // shared bus out to memory
  assign wb_cyc_o      = mem_bus.cyc;
  assign wb_stb_o      = mem_bus.stb;
  assign wb_we_o       = mem_bus.we;
  assign wb_adr_o      = mem_bus.adr;
  assign wb_sel_o      = mem_bus.sel;
  assign wb_dat_o      = mem_bus.dat_w;
  assign mem_bus.dat_r = wb_dat_i;
  assign mem_bus.ack   = wb_ack_i;
  assign mem_bus.err   = wb_err_i;

endmodule

// ==== tb_wb_mem.sv ====
// behavioural 128 bit memory on the classic bus
// 64 lines, ack after 0 to 3 wait cycles from an xorshift source
// answers with err instead of ack while err_next_i is high
`timescale 1ns/1ps

`include "gfx_mem_cfg.svh"

module tb_wb_mem
  import gfx_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  logic [`GFX_ADDR_W-1:0] adr_i,
  input  sel_t                   sel_i,
  input  line_t                  dat_i,
  output line_t                  dat_o,
  output logic                   ack_o,
  output logic                   err_o,
  input  logic                   err_next_i // next completion is an err
);

  line_t       mem [64];
  logic [31:0] rng = 32'h6325;
  logic        busy;   // wait cycles already drawn for this cycle
  logic [1:0]  wait_q;
  logic [5:0]  idx;

  assign idx = adr_i[9:4]; // line number inside the model

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every 32 bit word gets its own value from its byte address
  initial
  begin
    for (int i = 0; i < 64; i++)
      for (int w = 0; w < 4; w++)
        mem[i][w*32 +: 32] = ((i * 16 + w * 4) * 32'h9e3779b1) ^ 32'h5bd1e995;
  end

  always @(posedge clk_i)
  begin : serve
    logic [1:0] left;
    ack_o <= 1'b0; // completions are single cycle pulses
    err_o <= 1'b0;
    if (rst_i)
    begin
      busy  <= 1'b0;
      dat_o <= '0;
    end
    else if (cyc_i && stb_i && !ack_o && !err_o)
    begin
      if (busy)
        left = wait_q;
      else
      begin
        rng  = xorshift(rng);
        left = rng[1:0]; // 0 to 3 wait cycles
      end
      if (left == 2'd0)
      begin
        busy <= 1'b0;
        if (err_next_i)
        begin
          err_o <= 1'b1; // nothing stored, read data zero
          dat_o <= '0;
        end
        else
        begin
          ack_o <= 1'b1;
          if (we_i)
          begin
            for (int b = 0; b < LINE_BYTES; b++)
              if (sel_i[b])
                mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
          end
          else
            dat_o <= mem[idx];
        end
      end
      else
      begin
        busy   <= 1'b1;
        wait_q <= left - 2'd1;
      end
    end
  end

endmodule

// ==== tb_gfx_mem_port.sv ====
// testbench for the pixel memory port
// stimulus table of colour, depth, read and err entries
// reference line model with the field merge and depth rules
// credit bookkeeping, snoop latency and irq checks, cycle limit
`timescale 1ns/1ps

`include "gfx_mem_cfg.svh"

module tb_gfx_mem_port
  import gfx_bus_pkg::*;
  import gfx_pixel_pkg::*;
();

  localparam int NUM_ENTRIES = 23;
  localparam int ENTRY_CYC   = 200; // per entry budget
  localparam int TIMEOUT_CYC = ENTRY_CYC * NUM_ENTRIES;

  typedef enum {OP_COLOR, OP_DEPTH, OP_READ, OP_ERR} op_e;

  typedef struct {
    op_e         op;
    logic [31:0] adr;
    logic [31:0] dat;
    int          mb;
    int          me;
    bit          hit; // read expected from the writer buffer
  } entry_t;

  logic                   clk_i;
  logic                   rst_i;
  logic                   cmd_valid_i;
  pix_kind_e              cmd_kind_i;
  logic [`GFX_ADDR_W-1:0] cmd_adr_i;
  logic [31:0]            cmd_dat_i;
  logic [6:0]             cmd_mb_i;
  logic [6:0]             cmd_me_i;
  logic                   cmd_credit_o;
  logic                   rd_req_i;
  line_adr_t              rd_adr_i;
  logic                   rd_ready_o;
  logic                   rd_valid_o;
  line_t                  rd_data_o;
  logic                   wb_cyc_o;
  logic                   wb_stb_o;
  logic                   wb_we_o;
  logic [`GFX_ADDR_W-1:0] wb_adr_o;
  sel_t                   wb_sel_o;
  line_t                  wb_dat_o;
  line_t                  wb_dat_i;
  logic                   wb_ack_i;
  logic                   wb_err_i;
  logic                   irq_o;
  logic                   err_next;

  entry_t tbl [NUM_ENTRIES];
  line_t  model [64];   // latest value of every line as the renderer sees it
  int     credits;      // source credits in hand
  int     sent;
  int     returned;
  int     quiet;        // consecutive cycles with the bus idle
  int     errors;
  int     bad_entries;
  int     cycles = 0;
  logic   irq_exp;

  gfx_mem_port i_gfx_mem_port (
    .clk_i, .rst_i, .cmd_valid_i, .cmd_kind_i, .cmd_adr_i, .cmd_dat_i, .cmd_mb_i,
    .cmd_me_i, .cmd_credit_o, .rd_req_i, .rd_adr_i, .rd_ready_o, .rd_valid_o, .rd_data_o,
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o, .wb_dat_i,
    .wb_ack_i, .wb_err_i, .irq_o
  );

  tb_wb_mem i_wb_mem (
    .clk_i, .rst_i, .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .we_i(wb_we_o), .adr_i(wb_adr_o),
    .sel_i(wb_sel_o), .dat_i(wb_dat_o), .dat_o(wb_dat_i), .ack_o(wb_ack_i),
    .err_o(wb_err_i), .err_next_i(err_next)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i; // 8 ns period
  end

  always @(posedge clk_i)
  begin
    if (!rst_i)
      cycles++;
    if (cycles >= TIMEOUT_CYC)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic flag_error(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  // one clock, then 1 ns for outputs to settle and inputs to change
  task automatic step();
    @(posedge clk_i);
    #1;
    if (cmd_credit_o)
    begin
      credits++;
      returned++;
      assert (credits <= `GFX_CMD_DEPTH)
        else flag_error($sformatf("credit count %0d above queue depth", credits));
    end
    if (wb_cyc_o)
      quiet = 0;
    else
      quiet++;
  endtask

  // last pop can still be mid write-back or fetch, so wait for an idle bus too
  task automatic drain();
    int waited;
    waited = 0;
    while (credits != `GFX_CMD_DEPTH && waited < ENTRY_CYC)
    begin
      step();
      waited++;
    end
    assert (credits == `GFX_CMD_DEPTH)
      else flag_error($sformatf("only %0d of %0d credits back", credits, `GFX_CMD_DEPTH));
    quiet = 0;
    while (quiet < 4)
      step();
  endtask

  function automatic int line_idx(input logic [31:0] adr);
    return int'(adr[9:4]);
  endfunction

  // mask is mb..me, or mb upward plus me downward when it wraps
  function automatic line_t field_merge(input line_t old, input logic [31:0] dat,
                                        input int mb, input int me);
    line_t mask;
    line_t shifted;
    for (int n = 0; n < `GFX_LINE_W; n++)
      if (mb <= me)
        mask[n] = (n >= mb) && (n <= me);
      else
        mask[n] = (n >= mb) || (n <= me);
    shifted = {96'b0, dat} << mb;
    return (shifted & mask) | (old & ~mask);
  endfunction

  task automatic add_entry(input int n, input op_e op, input logic [31:0] adr,
                           input logic [31:0] dat, input int mb, input int me, input bit hit);
    tbl[n].op  = op;
    tbl[n].adr = adr;
    tbl[n].dat = dat;
    tbl[n].mb  = mb;
    tbl[n].me  = me;
    tbl[n].hit = hit;
  endtask

  task automatic send_cmd(input int e, input pix_kind_e kind);
    while (credits == 0) // source honours credits
      step();
    cmd_valid_i = 1'b1;
    cmd_kind_i  = kind;
    cmd_adr_i   = tbl[e].adr;
    cmd_dat_i   = tbl[e].dat;
    cmd_mb_i    = 7'(tbl[e].mb);
    cmd_me_i    = 7'(tbl[e].me);
    credits--;
    sent++;
    step();
    cmd_valid_i = 1'b0;
  endtask

  task automatic read_line(input int e, input bit arm_err);
    int    lat;
    int    idx;
    line_t got;
    idx = line_idx(tbl[e].adr);
    drain();
    while (!rd_ready_o)
      step();
    err_next = arm_err;
    rd_req_i = 1'b1;
    rd_adr_i = tbl[e].adr[31:4];
    step(); // accepted on this edge
    rd_req_i = 1'b0;
    assert (!rd_ready_o) else flag_error("rd_ready_o still high with a read in flight");
    lat = 1;
    while (!rd_valid_o)
    begin
      step();
      lat++;
    end
    got      = rd_data_o;
    err_next = 1'b0;
    assert (rd_ready_o) else flag_error("rd_ready_o low after the read returned");
    if (tbl[e].hit)
      assert (lat == 2) else flag_error($sformatf("snoop hit took %0d cycles", lat));
    else
      assert (lat > 2) else flag_error("read answered by the buffer, memory read expected");
    if (!arm_err)
    begin
      assert (got === model[idx])
        else flag_error($sformatf("line %h read %h, expected %h", tbl[e].adr, got, model[idx]));
      if (!tbl[e].hit)
        assert (i_wb_mem.mem[idx] === model[idx])
          else flag_error($sformatf("memory line %h holds %h", tbl[e].adr, i_wb_mem.mem[idx]));
    end
  endtask

  task automatic run_entry(input int e);
    int idx;
    int err_before;
    idx        = line_idx(tbl[e].adr);
    err_before = errors;
    case (tbl[e].op)
      OP_COLOR:
      begin
        send_cmd(e, PIX_COLOR);
        model[idx] = field_merge(model[idx], tbl[e].dat, tbl[e].mb, tbl[e].me);
      end
      OP_DEPTH:
      begin
        send_cmd(e, PIX_DEPTH);
        model[idx][tbl[e].mb +: 16] = tbl[e].dat[15:0]; // only the low z half is stored
        drain();
        assert (i_wb_mem.mem[idx][tbl[e].mb +: 16] === tbl[e].dat[15:0])
          else flag_error($sformatf("z %h missing in memory line %h", tbl[e].dat[15:0],
                                    tbl[e].adr));
      end
      OP_READ:
        read_line(e, 1'b0);
      default:
      begin
        irq_exp = 1'b1; // sticky from here on
        read_line(e, 1'b1);
      end
    endcase
    assert (irq_o === irq_exp)
      else flag_error($sformatf("irq_o %b, expected %b", irq_o, irq_exp));
    if (errors != err_before)
      bad_entries++;
    $display("entry %0d %s adr %h: %s", e, tbl[e].op.name(), tbl[e].adr,
             (errors == err_before) ? "ok" : "FAIL");
  endtask

  initial
  begin
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_kind_i  = PIX_COLOR;
    cmd_adr_i   = '0;
    cmd_dat_i   = '0;
    cmd_mb_i    = '0;
    cmd_me_i    = '0;
    rd_req_i    = 1'b0;
    rd_adr_i    = '0;
    err_next    = 1'b0;
    irq_exp     = 1'b0;
    credits     = `GFX_CMD_DEPTH;
    sent        = 0;
    returned    = 0;
    quiet       = 0;
    errors      = 0;
    bad_entries = 0;
    // line A 0x40, B 0x100, C 0x200, D 0x300
    add_entry(0,  OP_COLOR, 32'h040, 32'h0000_00ff, 0,   7,   0); // mb < me
    add_entry(1,  OP_COLOR, 32'h040, 32'h0000_0001, 20,  20,  0); // single bit
    add_entry(2,  OP_COLOR, 32'h044, 32'hdead_beef, 120, 11,  0); // wraps
    add_entry(3,  OP_COLOR, 32'h048, 32'h1234_5678, 64,  95,  0);
    add_entry(4,  OP_READ,  32'h040, 32'h0,         0,   0,   1);
    add_entry(5,  OP_COLOR, 32'h100, 32'habcd_0123, 32,  47,  0); // evicts dirty A
    add_entry(6,  OP_COLOR, 32'h10c, 32'h8bad_f00d, 100, 90,  0);
    add_entry(7,  OP_READ,  32'h040, 32'h0,         0,   0,   0); // A from memory
    add_entry(8,  OP_DEPTH, 32'h100, 32'h0000_5a5a, 48,  0,   0); // buffered line
    add_entry(9,  OP_READ,  32'h100, 32'h0,         0,   0,   1);
    add_entry(10, OP_DEPTH, 32'h200, 32'hffff_c3c3, 112, 0,   0); // not buffered
    add_entry(11, OP_READ,  32'h200, 32'h0,         0,   0,   0);
    add_entry(12, OP_COLOR, 32'h200, 32'h0000_a5a5, 8,   15,  0); // burst that fills the queue
    add_entry(13, OP_COLOR, 32'h300, 32'hc001_d00d, 0,   127, 0);
    add_entry(14, OP_COLOR, 32'h040, 32'h0f0f_0f0f, 4,   3,   0);
    add_entry(15, OP_COLOR, 32'h100, 32'h0000_0077, 16,  23,  0);
    add_entry(16, OP_COLOR, 32'h200, 32'h7654_3210, 127, 0,   0);
    add_entry(17, OP_READ,  32'h200, 32'h0,         0,   0,   1);
    add_entry(18, OP_READ,  32'h300, 32'h0,         0,   0,   0);
    add_entry(19, OP_ERR,   32'h3c0, 32'h0,         0,   0,   0);
    add_entry(20, OP_COLOR, 32'h040, 32'hcafe_f00d, 0,   31,  0);
    add_entry(21, OP_READ,  32'h040, 32'h0,         0,   0,   1);
    add_entry(22, OP_READ,  32'h100, 32'h0,         0,   0,   0);
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    for (int i = 0; i < 64; i++)
      model[i] = i_wb_mem.mem[i]; // start from the memory contents
    for (int e = 0; e < NUM_ENTRIES; e++)
      run_entry(e);
    drain();
    assert (returned == sent)
      else flag_error($sformatf("%0d credits back for %0d commands", returned, sent));
    $display("%0d entries, %0d failed, %0d errors, %0d commands, %0d credits back",
             NUM_ENTRIES, bad_entries, errors, sent, returned);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
gfx_bus_pkg.sv
gfx_pixel_pkg.sv
gfx_pix_if.sv
gfx_wb_if.sv
gfx_cmd_queue.sv
gfx_wbm_write.sv
gfx_wbm_read.sv
gfx_wb_arbiter.sv
gfx_mem_port.sv
tb_wb_mem.sv
tb_gfx_mem_port.sv
